// File: project.f
source/cam_pkg.sv
source/cam_serial_link.sv
source/cam_control.sv
source/adc_spi_port.sv
source/i2c_request.sv
source/cam_top.sv
bench/cam_models.sv
bench/cam_tb.sv

// File: Bender.yml
package:
  name: cam_port

sources:
  - source/cam_pkg.sv
  - source/cam_serial_link.sv
  - source/cam_control.sv
  - source/adc_spi_port.sv
  - source/i2c_request.sv
  - source/cam_top.sv
  - target: test
    files:
      - bench/cam_models.sv
      - bench/cam_tb.sv

// File: bench/cam_tb.sv
`timescale 1ns/1ps

module cam_tb;
	import cam_pkg::*;

	localparam int CLK_PERIOD      = 10;
	localparam int RESET_CYCLES    = 10;
	localparam int HOLD_CYCLES     = 4;             // clk cycles per sck phase
	localparam int MSG_BITS        = 64;
	localparam int PULSE_CYCLES    = 21;            // dut default
	localparam int SPI_HALF        = 21;            // dut default
	localparam logic [15:0] PB_RD  = 16'hC35A;      // power board read bytes
	localparam logic [15:0] SNS_RD = 16'h96E1;      // sensor board read bytes

	// run length bounds
	localparam int FRAME_CYCLES = 2 * MSG_BITS * 2 * HOLD_CYCLES + 64;  // in, out, slack
	localparam int ADC_CYCLES   = (2 * 16 + 2) * SPI_HALF;
	localparam int I2C_CYCLES   = 8 + 12 + 8;                           // wait, busy, slack
	localparam int RSP_TIMEOUT  = ADC_CYCLES + I2C_CYCLES + 100;
	localparam int N_FRAMES     = 17;                                   // 4 + 2 + 2 + 5 + 4
	localparam longint WATCHDOG_NS = longint'(3 * (N_FRAMES * FRAME_CYCLES
		+ 2 * ADC_CYCLES + 4 * I2C_CYCLES + RESET_CYCLES) / 2) * CLK_PERIOD;

	logic        clk;
	logic        n_reset;
	logic        sck;
	logic        din;
	logic        dout;
	logic        rsp_ready;
	cam_args_t   cmd_args;
	adc_pins_t   adc;
	logic        adc_sdo;
	logic        spi_fifo_rst;
	logic        acq_en;
	i2c_type_e   type_i2c;
	logic        start_pb_i2c;
	logic        status_pb_i2c;
	i2c_rd_t     pb_rd;
	logic        start_sns_i2c;
	logic        status_sns_i2c;
	i2c_rd_t     sns_rd;

	int unsigned adc_rises;
	logic [15:0] adc_sdi_word;
	int unsigned i2c_wait = 1;
	int unsigned i2c_busy = 1;
	i2c_type_e   exp_type = I2C_WRITE;
	logic [31:0] lcg_state = 32'hb03c;
	int          errors = 0;
	int          checks = 0;
	int          sync_pulses = 0;
	int          fifo_pulses = 0;
	int          pb_starts = 0;
	int          sns_starts = 0;
	int          sync_len = 0;
	int          fifo_len = 0;
	logic        pb_prev;
	logic        sns_prev;

	cam_top dut0 (
		.clk, .n_reset, .sck, .din, .dout, .rsp_ready, .cmd_args, .adc, .adc_sdo,
		.spi_fifo_rst, .acq_en, .type_i2c, .start_pb_i2c, .status_pb_i2c, .pb_rd,
		.start_sns_i2c, .status_sns_i2c, .sns_rd
	);

	adc_model adc_m (
		.clk, .n_reset, .adc, .adc_sdo, .rise_cnt(adc_rises), .sdi_word(adc_sdi_word)
	);

	i2c_model #(.RD_WORD(PB_RD)) pb_m (
		.clk, .start(start_pb_i2c), .wait_cycles(i2c_wait), .busy_cycles(i2c_busy),
		.status(status_pb_i2c), .rd(pb_rd)
	);

	i2c_model #(.RD_WORD(SNS_RD)) sns_m (
		.clk, .start(start_sns_i2c), .wait_cycles(i2c_wait), .busy_cycles(i2c_busy),
		.status(status_sns_i2c), .rd(sns_rd)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_val(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		assert (actual === expected)
		else begin
			errors++;
			$display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	function automatic cam_frame_t random_frame(input logic [7:0] opcode);
		cam_frame_t  f;
		logic [31:0] r;
		r = next_random();
		f.stx    = 8'h02;
		f.opcode = opcode;
		{f.arg1, f.arg0, f.pay1, f.pay0} = r;
		f.cs     = opcode ^ r[31:24] ^ r[23:16] ^ r[15:8] ^ r[7:0];  // xor over body
		f.etx    = 8'h03;
		return f;
	endfunction

	// response = command with payload replaced per opcode
	function automatic cam_frame_t expected_response(input cam_frame_t cmd);
		cam_frame_t rsp;
		rsp = cmd;
		case (cmd.opcode)
			8'd0:  {rsp.pay1, rsp.pay0} = 16'hAA55;             // test word
			8'd16: {rsp.pay1, rsp.pay0} = 16'h2300;             // version
			8'd1:  {rsp.pay1, rsp.pay0} = ~{cmd.arg1, cmd.arg0}; // model inverts sdi
			8'd8:  {rsp.pay1, rsp.pay0} = PB_RD;
			8'd11: {rsp.pay1, rsp.pay0} = SNS_RD;
			default: ;
		endcase
		return rsp;
	endfunction

	// --------------------------------------------------
	// host side of the serial link
	// --------------------------------------------------
	task automatic send_frame(input cam_frame_t f);
		for (int i = MSG_BITS - 1; i >= 0; i--) begin
			din <= f[i];                                  // msb first
			repeat (HOLD_CYCLES) @(posedge clk);
			sck <= 1'b1;
			repeat (HOLD_CYCLES) @(posedge clk);
			sck <= 1'b0;
		end
		din <= 1'b0;
	endtask

	task automatic read_frame(output cam_frame_t f);
		for (int i = MSG_BITS - 1; i >= 0; i--) begin
			sck <= 1'b1;                                  // link puts next bit out
			repeat (HOLD_CYCLES) @(posedge clk);
			sck <= 1'b0;
			@(negedge clk);
			f[i] = dout;                                  // host falling edge
			repeat (HOLD_CYCLES) @(posedge clk);
		end
	endtask

	task automatic run_command(input cam_frame_t cmd, output cam_frame_t rsp);
		int waited;
		send_frame(cmd);
		waited = 0;
		@(negedge clk);
		while (!rsp_ready && waited < RSP_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		if (rsp_ready) begin
			read_frame(rsp);
			@(negedge clk);
			check_val("rsp_ready after response", 1'b0, rsp_ready);
			check_val("dout after response", 1'b0, dout);
			@(posedge clk);
		end else begin
			errors++;
			$display("no response: rsp_ready stayed low %0d cycles after opcode %0d",
				waited, cmd.opcode);
			rsp = '0;
		end
	endtask

	task automatic check_response(input string name, input cam_frame_t cmd,
		input cam_frame_t rsp);
		check_val({name, " response"}, expected_response(cmd), rsp);
		check_val({name, " cmd_args"}, {cmd.arg1, cmd.arg0, cmd.pay1, cmd.pay0}, cmd_args);
	endtask

	// --------------------------------------------------
	// test sections
	// --------------------------------------------------
	task automatic check_reset_state();
		@(negedge clk);
		check_val("reset adc pins", 4'b0101, adc);    // sck, n_cs, sdi, n_sync_in
		check_val("reset spi_fifo_rst", 1'b0, spi_fifo_rst);
		check_val("reset acq_en", 1'b0, acq_en);
		check_val("reset start_pb_i2c", 1'b0, start_pb_i2c);
		check_val("reset start_sns_i2c", 1'b0, start_sns_i2c);
		check_val("reset dout", 1'b0, dout);
		check_val("reset rsp_ready", 1'b0, rsp_ready);
		check_val("reset cmd_args", 32'h0, cmd_args);
		@(posedge clk);
	endtask

	task automatic simple_opcodes();
		logic [7:0] ops [4];
		cam_frame_t cmd;
		cam_frame_t rsp;
		ops = '{8'd0, 8'd16, 8'd6, 8'd200};           // test, version, two echoes
		foreach (ops[i]) begin
			cmd = random_frame(ops[i]);
			run_command(cmd, rsp);
			check_response($sformatf("opcode %0d", ops[i]), cmd, rsp);
		end
	endtask

	task automatic adc_exchange();
		cam_frame_t cmd;
		cam_frame_t rsp;
		repeat (2) begin
			cmd = random_frame(8'd1);
			run_command(cmd, rsp);
			check_response("adc exchange", cmd, rsp);
			check_val("adc sck rises", 16, adc_rises);
			check_val("adc sdi bits", {cmd.arg1, cmd.arg0}, adc_sdi_word);
			check_val("adc n_cs after exchange", 1'b1, adc.n_cs);
		end
	endtask

	task automatic pulse_commands();
		cam_frame_t cmd;
		cam_frame_t rsp;
		int         sync_before;
		int         fifo_before;
		sync_before = sync_pulses;
		fifo_before = fifo_pulses;
		cmd = random_frame(8'd2);
		run_command(cmd, rsp);
		check_response("adc sync", cmd, rsp);
		check_val("sync pulses after opcode 2", sync_before + 1, sync_pulses);
		check_val("fifo pulses after opcode 2", fifo_before, fifo_pulses);
		cmd = random_frame(8'd3);
		run_command(cmd, rsp);
		check_response("fifo reset", cmd, rsp);
		check_val("sync pulses after opcode 3", sync_before + 1, sync_pulses);
		check_val("fifo pulses after opcode 3", fifo_before + 1, fifo_pulses);
	endtask

	task automatic acquisition_level();
		logic [7:0] ops [5];
		logic       levels [5];
		cam_frame_t cmd;
		cam_frame_t rsp;
		ops    = '{8'd4, 8'd0, 8'd2, 8'd5, 8'd16};     // level must hold across 0 and 2
		levels = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0};
		foreach (ops[i]) begin
			cmd = random_frame(ops[i]);
			run_command(cmd, rsp);
			check_response($sformatf("acq step %0d", i), cmd, rsp);
			check_val($sformatf("acq_en after opcode %0d", ops[i]), levels[i], acq_en);
		end
	endtask

	task automatic i2c_requests();
		logic [7:0] ops [4];
		cam_frame_t cmd;
		cam_frame_t rsp;
		int         pb_before;
		int         sns_before;
		bit         on_pb;
		ops = '{8'd7, 8'd8, 8'd10, 8'd11};
		foreach (ops[i]) begin
			on_pb      = ops[i] inside {8'd7, 8'd8};
			exp_type   = (ops[i] inside {8'd8, 8'd11}) ? I2C_READ : I2C_WRITE;
			i2c_wait   <= 1 + (next_random() >> 16) % 8;
			i2c_busy   <= 1 + (next_random() >> 16) % 12;
			pb_before  = pb_starts;
			sns_before = sns_starts;
			cmd = random_frame(ops[i]);
			run_command(cmd, rsp);
			check_response($sformatf("i2c opcode %0d", ops[i]), cmd, rsp);
			check_val("power board start count", pb_before + on_pb, pb_starts);
			check_val("sensor board start count", sns_before + !on_pb, sns_starts);
			check_val("type_i2c held", exp_type, type_i2c);
		end
	endtask

	// --------------------------------------------------
	// monitors
	// --------------------------------------------------
	always @(negedge clk) begin
		if (!n_reset) begin
			sync_len = 0;
			fifo_len = 0;
		end else begin
			if (!adc.n_sync_in) begin
				sync_len++;
			end else if (sync_len != 0) begin
				sync_pulses++;
				check_val("n_sync_in pulse width", PULSE_CYCLES, sync_len);
				sync_len = 0;
			end
			if (spi_fifo_rst) begin
				fifo_len++;
			end else if (fifo_len != 0) begin
				fifo_pulses++;
				check_val("spi_fifo_rst pulse width", PULSE_CYCLES, fifo_len);
				fifo_len = 0;
			end
		end
	end

	always @(negedge clk) begin
		if (n_reset) begin
			if (start_pb_i2c && !pb_prev) begin
				pb_starts++;
				check_val("type_i2c at power board start", exp_type, type_i2c);
			end
			if (start_sns_i2c && !sns_prev) begin
				sns_starts++;
				check_val("type_i2c at sensor board start", exp_type, type_i2c);
			end
		end
		pb_prev  = start_pb_i2c;
		sns_prev = start_sns_i2c;
	end

	a_cs_spans_word: assert property (@(posedge clk) disable iff (!n_reset)
		$rose(adc.n_cs) |-> adc_rises == 16)
	else begin
		errors++;
		$display("adc chip select rose after %0d sck rises instead of 16", adc_rises);
	end

	a_sck_in_cs: assert property (@(posedge clk) disable iff (!n_reset)
		$rose(adc.sck) |-> !adc.n_cs)
	else begin
		errors++;
		$display("adc sck rose while chip select was high");
	end

	a_pulses_apart: assert property (@(posedge clk) disable iff (!n_reset)
		!(spi_fifo_rst && !adc.n_sync_in))
	else begin
		errors++;
		$display("sync and fifo reset pulses overlapped");
	end

	a_starts_apart: assert property (@(posedge clk) disable iff (!n_reset)
		!(start_pb_i2c && start_sns_i2c))
	else begin
		errors++;
		$display("both i2c start lines were high together");
	end

	a_pb_start_held: assert property (@(posedge clk) disable iff (!n_reset)
		(start_pb_i2c && !status_pb_i2c) |=> start_pb_i2c)
	else begin
		errors++;
		$display("power board start dropped before its status rose");
	end

	a_sns_start_held: assert property (@(posedge clk) disable iff (!n_reset)
		(start_sns_i2c && !status_sns_i2c) |=> start_sns_i2c)
	else begin
		errors++;
		$display("sensor board start dropped before its status rose");
	end

	a_pb_start_fall: assert property (@(posedge clk) disable iff (!n_reset)
		$fell(start_pb_i2c) |-> $past(status_pb_i2c))
	else begin
		errors++;
		$display("power board start fell without status high");
	end

	a_sns_start_fall: assert property (@(posedge clk) disable iff (!n_reset)
		$fell(start_sns_i2c) |-> $past(status_sns_i2c))
	else begin
		errors++;
		$display("sensor board start fell without status high");
	end

	// --------------------------------------------------
	// main sequence and watchdog
	// --------------------------------------------------
	initial begin
		n_reset = 1'b0;
		sck     = 1'b0;
		din     = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		n_reset <= 1'b1;
		check_reset_state();
		simple_opcodes();
		adc_exchange();
		pulse_commands();
		acquisition_level();
		i2c_requests();
		repeat (10) @(posedge clk);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: run still going after %0d ns, stopping", WATCHDOG_NS);
		$display("%0d checks, %0d errors", checks, errors);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: bench/cam_models.sv
`timescale 1ns/1ps

// --------------------------------------------------
// adc control port
// --------------------------------------------------
module adc_model (
	input  logic               clk,
	input  logic               n_reset,
	input  cam_pkg::adc_pins_t adc,
	output logic               adc_sdo,
	output int unsigned        rise_cnt,    // sck rises in this exchange
	output logic [15:0]        sdi_word     // sdi bits seen at those rises
);
	logic sck_prev;
	logic n_cs_prev;

	assign adc_sdo = (adc.sdi === 1'b1) ? 1'b0 : 1'b1;   // inverted echo of sdi

	always @(posedge clk) begin
		if (!n_reset) begin
			sck_prev  <= 1'b0;
			n_cs_prev <= 1'b1;
			rise_cnt  <= 0;
			sdi_word  <= '0;
		end else begin
			sck_prev  <= adc.sck;
			n_cs_prev <= adc.n_cs;
			if (n_cs_prev && !adc.n_cs) begin
				rise_cnt <= 0;                      // new exchange
				sdi_word <= '0;
			end else if (adc.sck && !sck_prev) begin
				rise_cnt <= rise_cnt + 1;
				sdi_word <= {sdi_word[14:0], adc.sdi};  // msb arrives first
			end
		end
	end
endmodule

// --------------------------------------------------
// i2c engine, start/status handshake
// --------------------------------------------------
module i2c_model #(
	parameter logic [15:0] RD_WORD = 16'h0000
) (
	input  logic             clk,
	input  logic             start,
	input  int unsigned      wait_cycles,   // start seen to status high
	input  int unsigned      busy_cycles,   // status high time
	output logic             status,
	output cam_pkg::i2c_rd_t rd
);
	assign rd = RD_WORD;                    // fixed read bytes

	initial status = 1'b0;

	always begin
		@(posedge clk);
		if (start) begin
			repeat (wait_cycles) @(posedge clk);
			status <= 1'b1;                     // engine took the request
			repeat (busy_cycles) @(posedge clk);
			status <= 1'b0;
		end
	end
endmodule

// File: source/cam_top.sv
`timescale 1ns/1ps

module cam_top #(
	parameter int PULSE_CYCLES    = 21,     // sync / fifo reset width
	parameter int SPI_HALF_CYCLES = 21      // adc sck half period
) (
	input  logic                clk,
	input  logic                n_reset,
	input  logic                sck,
	input  logic                din,
	output logic                dout,
	output logic                rsp_ready,
	output cam_pkg::cam_args_t  cmd_args,
	output cam_pkg::adc_pins_t  adc,
	input  logic                adc_sdo,
	output logic                spi_fifo_rst,
	output logic                acq_en,
	output cam_pkg::i2c_type_e  type_i2c,
	output logic                start_pb_i2c,
	input  logic                status_pb_i2c,
	input  cam_pkg::i2c_rd_t    pb_rd,
	output logic                start_sns_i2c,
	input  logic                status_sns_i2c,
	input  cam_pkg::i2c_rd_t    sns_rd
);
	import cam_pkg::*;

	logic                      frame_valid;
	cam_frame_t                frame_in;
	logic                      rsp_load;
	cam_frame_t                frame_out;
	logic                      adc_start;
	logic [ADC_WORD_BITS-1:0]  adc_wr_word;
	logic                      adc_done;
	logic [ADC_WORD_BITS-1:0]  adc_rd_word;
	logic                      adc_sck;
	logic                      adc_n_cs;
	logic                      adc_sdi;
	logic                      adc_n_sync_in;
	logic                      i2c_start;
	i2c_bus_e                  i2c_bus;
	i2c_type_e                 i2c_type;
	logic                      i2c_done;
	i2c_rd_t                   i2c_rd;

	cam_serial_link link0 (
		.clk, .n_reset, .sck, .din, .rsp_load, .frame_out,
		.dout, .rsp_ready, .frame_valid, .frame_in
	);

	cam_control #(.PULSE_CYCLES(PULSE_CYCLES)) ctrl0 (
		.clk, .n_reset, .frame_valid, .frame_in, .adc_done, .adc_rd_word,
		.i2c_done, .i2c_rd, .rsp_load, .frame_out, .cmd_args, .adc_start,
		.adc_wr_word, .adc_n_sync_in, .spi_fifo_rst, .acq_en,
		.i2c_start, .i2c_bus, .i2c_type
	);

	adc_spi_port #(.SPI_HALF_CYCLES(SPI_HALF_CYCLES)) adc0 (
		.clk, .n_reset, .adc_start, .adc_wr_word, .adc_sdo,
		.adc_done, .adc_rd_word, .adc_sck, .adc_n_cs, .adc_sdi
	);

	i2c_request i2c0 (
		.clk, .n_reset, .i2c_start, .i2c_bus, .i2c_type,
		.status_pb_i2c, .status_sns_i2c, .pb_rd, .sns_rd,
		.i2c_done, .i2c_rd, .type_i2c, .start_pb_i2c, .start_sns_i2c
	);

	// adc pins out as one bundle
	assign adc = '{sck: adc_sck, n_cs: adc_n_cs, sdi: adc_sdi, n_sync_in: adc_n_sync_in};

endmodule

// File: source/i2c_request.sv
`timescale 1ns/1ps

module i2c_request (
	input  logic                clk,
	input  logic                n_reset,
	input  logic                i2c_start,
	input  cam_pkg::i2c_bus_e   i2c_bus,
	input  cam_pkg::i2c_type_e  i2c_type,
	input  logic                status_pb_i2c,   // engine busy, power board
	input  logic                status_sns_i2c,  // engine busy, sensor board
	input  cam_pkg::i2c_rd_t    pb_rd,
	input  cam_pkg::i2c_rd_t    sns_rd,
	output logic                i2c_done,
	output cam_pkg::i2c_rd_t    i2c_rd,
	output cam_pkg::i2c_type_e  type_i2c,
	output logic                start_pb_i2c,
	output logic                start_sns_i2c
);
	import cam_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_BUSY,                              // start held until engine takes it
		WAIT_FREE                               // engine running
	} state_e;

	state_e    state;
	i2c_bus_e  bus_r;
	logic      status_sel;
	i2c_rd_t   rd_sel;

	assign status_sel = (bus_r == BUS_PB) ? status_pb_i2c : status_sns_i2c;
	assign rd_sel     = (bus_r == BUS_PB) ? pb_rd : sns_rd;

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state         <= IDLE;
			bus_r         <= BUS_PB;
			type_i2c      <= I2C_WRITE;
			start_pb_i2c  <= 1'b0;
			start_sns_i2c <= 1'b0;
			i2c_done      <= 1'b0;
		end else begin
			i2c_done <= 1'b0;
			case (state)
				IDLE: if (i2c_start) begin
					bus_r         <= i2c_bus;
					type_i2c      <= i2c_type;          // held until next request
					start_pb_i2c  <= (i2c_bus == BUS_PB);
					start_sns_i2c <= (i2c_bus == BUS_SNS);
					state         <= WAIT_BUSY;
				end
				WAIT_BUSY: if (status_sel) begin
					start_pb_i2c  <= 1'b0;              // rearm
					start_sns_i2c <= 1'b0;
					state         <= WAIT_FREE;
				end
				WAIT_FREE: if (!status_sel) begin
					i2c_done <= 1'b1;
					state    <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// read bytes sampled with done
	always_ff @(posedge clk) begin
		if (state == WAIT_FREE && !status_sel)
			i2c_rd <= rd_sel;
	end

	a_one_start: assert property (@(posedge clk) disable iff (!n_reset)
		!(start_pb_i2c && start_sns_i2c));

endmodule

// File: source/adc_spi_port.sv
`timescale 1ns/1ps

module adc_spi_port #(
	parameter int SPI_HALF_CYCLES = 21
) (
	input  logic                              clk,
	input  logic                              n_reset,
	input  logic                              adc_start,
	input  logic [cam_pkg::ADC_WORD_BITS-1:0] adc_wr_word,
	input  logic                              adc_sdo,      // from adc
	output logic                              adc_done,
	output logic [cam_pkg::ADC_WORD_BITS-1:0] adc_rd_word,
	output logic                              adc_sck,
	output logic                              adc_n_cs,
	output logic                              adc_sdi
);
	import cam_pkg::*;

	localparam int DLY_W  = $clog2(SPI_HALF_CYCLES + 1);
	localparam int BCNT_W = $clog2(ADC_WORD_BITS + 1);
	localparam logic [DLY_W-1:0] DLY_FULL  = DLY_W'(SPI_HALF_CYCLES - 1);
	localparam logic [DLY_W-1:0] DLY_SHORT = DLY_W'(SPI_HALF_CYCLES - 2);  // one cycle in RISE/FINISH

	typedef enum logic [2:0] {
		IDLE,
		SETUP,                                  // cs low before first edge
		RISE,
		HIGH,
		LOW,
		FINISH
	} state_e;

	state_e                    state;
	logic [DLY_W-1:0]          dly;
	logic [BCNT_W-1:0]         bit_cnt;
	logic [ADC_WORD_BITS-1:0]  tx_word;

	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state    <= IDLE;
			dly      <= '0;
			bit_cnt  <= '0;
			adc_done <= 1'b0;
			adc_sck  <= 1'b0;
			adc_n_cs <= 1'b1;
			adc_sdi  <= 1'b0;
		end else begin
			adc_done <= 1'b0;
			case (state)
				IDLE: if (adc_start) begin
					adc_n_cs <= 1'b0;                   // start exchange
					adc_sdi  <= adc_wr_word[ADC_WORD_BITS-1];
					dly      <= '0;
					bit_cnt  <= '0;
					state    <= SETUP;
				end
				SETUP: begin
					dly <= dly + 1'b1;
					if (dly == DLY_SHORT) begin
						dly   <= '0;
						state <= RISE;
					end
				end
				RISE: begin
					adc_sck <= 1'b1;                    // adc samples sdi here
					bit_cnt <= bit_cnt + 1'b1;
					dly     <= '0;
					state   <= HIGH;
				end
				HIGH: begin
					dly <= dly + 1'b1;
					if (dly == DLY_FULL) begin
						adc_sck <= 1'b0;
						adc_sdi <= tx_word[ADC_WORD_BITS-2];  // next bit in low phase
						dly     <= '0;
						state   <= LOW;
					end
				end
				LOW: begin
					dly <= dly + 1'b1;
					if (dly == DLY_SHORT) begin
						dly   <= '0;
						state <= (bit_cnt == BCNT_W'(ADC_WORD_BITS)) ? FINISH : RISE;
					end
				end
				FINISH: begin
					adc_n_cs <= 1'b1;
					adc_sdi  <= 1'b0;
					adc_done <= 1'b1;                   // word in adc_rd_word
					state    <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// shift registers
	always_ff @(posedge clk) begin
		if (state == IDLE && adc_start)
			tx_word <= adc_wr_word;
		else if (state == HIGH && dly == DLY_FULL)
			tx_word <= {tx_word[ADC_WORD_BITS-2:0], 1'b0};
		if (state == RISE)
			adc_rd_word <= {adc_rd_word[ADC_WORD_BITS-2:0], adc_sdo};  // sdo at each rise
	end

	a_sck_in_cs: assert property (@(posedge clk) disable iff (!n_reset)
		adc_sck |-> !adc_n_cs);

endmodule

// File: source/cam_control.sv
`timescale 1ns/1ps

module cam_control #(
	parameter int PULSE_CYCLES = 21
) (
	input  logic                                  clk,
	input  logic                                  n_reset,
	input  logic                                  frame_valid,
	input  cam_pkg::cam_frame_t                   frame_in,
	input  logic                                  adc_done,
	input  logic [cam_pkg::ADC_WORD_BITS-1:0]     adc_rd_word,
	input  logic                                  i2c_done,
	input  cam_pkg::i2c_rd_t                      i2c_rd,
	output logic                                  rsp_load,
	output cam_pkg::cam_frame_t                   frame_out,
	output cam_pkg::cam_args_t                    cmd_args,
	output logic                                  adc_start,
	output logic [cam_pkg::ADC_WORD_BITS-1:0]     adc_wr_word,
	output logic                                  adc_n_sync_in,
	output logic                                  spi_fifo_rst,
	output logic                                  acq_en,
	output logic                                  i2c_start,
	output cam_pkg::i2c_bus_e                     i2c_bus,
	output cam_pkg::i2c_type_e                    i2c_type
);
	import cam_pkg::*;

	localparam int PCNT_W = $clog2(PULSE_CYCLES + 1);

	typedef enum logic [2:0] {
		IDLE,
		DISPATCH,                               // kick the datapath port
		PULSE,                                  // sync or fifo reset active
		WAIT_ADC,
		WAIT_I2C,
		RESPOND                                 // hand frame to the link
	} state_e;

	state_e             state;
	cam_frame_t         frame_r;              // command being worked on
	cam_opcode_e        op;
	logic [PCNT_W-1:0]  pulse_cnt;

	assign op = cam_opcode_e'(frame_r.opcode);

	always_ff @(posedge clk) begin
		if (frame_valid)
			frame_r <= frame_in;
	end

	// --------------------------------------------------
	// command sequencer
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			state         <= IDLE;
			pulse_cnt     <= '0;
			adc_n_sync_in <= 1'b1;
			spi_fifo_rst  <= 1'b0;
			acq_en        <= 1'b0;
			cmd_args      <= '0;
		end else begin
			case (state)
				IDLE: if (frame_valid) begin
					cmd_args <= '{arg1: frame_in.arg1, arg0: frame_in.arg0,
						pay1: frame_in.pay1, pay0: frame_in.pay0};
					case (frame_in.opcode)
						OP_ACQ_START: begin
							acq_en <= 1'b1;             // samples into fifo
							state  <= RESPOND;
						end
						OP_ACQ_STOP: begin
							acq_en <= 1'b0;
							state  <= RESPOND;
						end
						OP_ADC_XFER, OP_ADC_SYNC, OP_FIFO_RST,
						OP_PB_WRITE, OP_PB_READ, OP_SNS_WRITE, OP_SNS_READ:
							state <= DISPATCH;
						default: state <= RESPOND;      // test, version, echo
					endcase
				end
				DISPATCH: begin
					pulse_cnt <= '0;
					case (op)
						OP_ADC_SYNC: begin
							adc_n_sync_in <= 1'b0;      // apply adc config
							state         <= PULSE;
						end
						OP_FIFO_RST: begin
							spi_fifo_rst <= 1'b1;
							state        <= PULSE;
						end
						OP_ADC_XFER: state <= WAIT_ADC;
						default:     state <= WAIT_I2C;  // the four i2c opcodes
					endcase
				end
				PULSE: begin
					pulse_cnt <= pulse_cnt + 1'b1;
					if (pulse_cnt == PCNT_W'(PULSE_CYCLES - 1)) begin
						adc_n_sync_in <= 1'b1;
						spi_fifo_rst  <= 1'b0;
						state         <= RESPOND;       // load lines up with pulse end
					end
				end
				WAIT_ADC: if (adc_done) state <= RESPOND;
				WAIT_I2C: if (i2c_done) state <= RESPOND;
				RESPOND:  state <= IDLE;
				default:  state <= IDLE;
			endcase
		end
	end

	// port requests, valid while in DISPATCH
	assign adc_start   = (state == DISPATCH) && (op == OP_ADC_XFER);
	assign adc_wr_word = {frame_r.arg1, frame_r.arg0};
	assign i2c_start   = (state == DISPATCH) &&
		(op inside {OP_PB_WRITE, OP_PB_READ, OP_SNS_WRITE, OP_SNS_READ});
	assign i2c_bus     = (op inside {OP_PB_WRITE, OP_PB_READ}) ? BUS_PB : BUS_SNS;
	assign i2c_type    = (op inside {OP_PB_READ, OP_SNS_READ}) ? I2C_READ : I2C_WRITE;

	// --------------------------------------------------
	// response payload merge
	// --------------------------------------------------
	always_comb begin
		frame_out = frame_r;                       // echo by default
		case (op)
			OP_TEST: begin
				frame_out.pay1 = TEST_HI;
				frame_out.pay0 = TEST_LO;
			end
			OP_VERSION: begin
				frame_out.pay1 = VER_MAJ;
				frame_out.pay0 = VER_MIN;
			end
			OP_ADC_XFER: {frame_out.pay1, frame_out.pay0} = adc_rd_word;
			OP_PB_READ, OP_SNS_READ: begin
				frame_out.pay1 = i2c_rd.data1;         // held by the i2c port
				frame_out.pay0 = i2c_rd.data0;
			end
			default: ;
		endcase
	end

	assign rsp_load = (state == RESPOND);

	// sync and fifo reset never overlap
	a_one_pulse: assert property (@(posedge clk) disable iff (!n_reset)
		!(spi_fifo_rst && !adc_n_sync_in));

endmodule

// File: source/cam_serial_link.sv
`timescale 1ns/1ps

module cam_serial_link (
	input  logic                clk,
	input  logic                n_reset,
	input  logic                sck,           // host serial clock
	input  logic                din,           // host to fpga
	input  logic                rsp_load,      // response frame ready from sequencer
	input  cam_pkg::cam_frame_t frame_out,
	output logic                dout,          // fpga to host
	output logic                rsp_ready,     // host may clock the response out
	output logic                frame_valid,
	output cam_pkg::cam_frame_t frame_in
);
	import cam_pkg::*;

	typedef enum logic [1:0] {
		RX,                                     // shifting a command in
		WAIT_RSP,                               // sck ignored here
		TX                                      // shifting the response out
	} mode_e;

	mode_e                    mode;
	logic                     sck_meta;
	logic                     sck_sync;
	logic                     sck_prev;
	logic                     rise;
	logic                     fall;
	logic [BIT_CNT_WIDTH-1:0] bit_cnt;        // shared by rx and tx
	logic [MSG_LENGTH-1:0]    rx_shift;
	logic [MSG_LENGTH-1:0]    tx_shift;

	// --------------------------------------------------
	// sck synchroniser and edge detect
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			sck_meta <= 1'b0;
			sck_sync <= 1'b0;
			sck_prev <= 1'b0;
		end else begin
			sck_meta <= sck;
			sck_sync <= sck_meta;
			sck_prev <= sck_sync;                   // history for edges
		end
	end

	assign rise = sck_sync & ~sck_prev;
	assign fall = ~sck_sync & sck_prev;

	// --------------------------------------------------
	// link control
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!n_reset) begin
			mode        <= RX;
			bit_cnt     <= '0;
			frame_valid <= 1'b0;
			dout        <= 1'b0;
			rsp_ready   <= 1'b0;
		end else begin
			frame_valid <= 1'b0;                    // single cycle strobe
			case (mode)
				RX: if (rise) begin
					if (bit_cnt == BIT_CNT_WIDTH'(MSG_LENGTH - 1)) begin
						bit_cnt     <= '0;
						frame_valid <= 1'b1;            // last bit just landed
						mode        <= WAIT_RSP;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
				WAIT_RSP: if (rsp_load) begin
					rsp_ready <= 1'b1;
					mode      <= TX;
				end
				TX: begin
					if (rise) begin
						dout    <= tx_shift[MSG_LENGTH-1];  // host samples on its fall
						bit_cnt <= bit_cnt + 1'b1;
					end else if (fall && bit_cnt == BIT_CNT_WIDTH'(MSG_LENGTH)) begin
						dout      <= 1'b0;
						rsp_ready <= 1'b0;
						bit_cnt   <= '0;
						mode      <= RX;                 // ready for next command
					end
				end
				default: mode <= RX;
			endcase
		end
	end

	// frame shift registers
	always_ff @(posedge clk) begin
		if (mode == RX && rise)
			rx_shift <= {rx_shift[MSG_LENGTH-2:0], din};    // msb first
		if (mode == WAIT_RSP && rsp_load)
			tx_shift <= frame_out;
		else if (mode == TX && rise)
			tx_shift <= {tx_shift[MSG_LENGTH-2:0], 1'b0};
	end

	assign frame_in = rx_shift;

	// line stays quiet outside a response
	a_dout_idle: assert property (@(posedge clk) disable iff (!n_reset)
		!rsp_ready |-> !dout);

endmodule

// File: source/cam_pkg.sv
package cam_pkg;

	// --------------------------------------------------
	// frame geometry
	// --------------------------------------------------
	localparam int MSG_LENGTH    = 64;            // bits per frame
	localparam int BIT_CNT_WIDTH = 7;             // must reach MSG_LENGTH itself

	localparam logic [7:0] TEST_HI = 8'hAA;       // test word readback
	localparam logic [7:0] TEST_LO = 8'h55;

	localparam logic [7:0] VER_MAJ = 8'h23;       // hardware v2.3
	localparam logic [7:0] VER_MIN = 8'h00;       // baseline

	localparam int ADC_WORD_BITS = 16;            // adc control port exchange

	// wire order, stx goes out first
	typedef struct packed {
		logic [7:0] stx;
		logic [7:0] opcode;
		logic [7:0] arg1;
		logic [7:0] arg0;
		logic [7:0] pay1;
		logic [7:0] pay0;
		logic [7:0] cs;                           // xor checksum, not checked
		logic [7:0] etx;
	} cam_frame_t;

	typedef struct packed {
		logic [7:0] arg1;
		logic [7:0] arg0;
		logic [7:0] pay1;
		logic [7:0] pay0;
	} cam_args_t;

	// --------------------------------------------------
	// opcodes, gaps echo the frame
	// --------------------------------------------------
	typedef enum logic [7:0] {
		OP_TEST      = 8'd0,
		OP_ADC_XFER  = 8'd1,
		OP_ADC_SYNC  = 8'd2,
		OP_FIFO_RST  = 8'd3,
		OP_ACQ_START = 8'd4,
		OP_ACQ_STOP  = 8'd5,
		OP_PB_WRITE  = 8'd7,
		OP_PB_READ   = 8'd8,
		OP_SNS_WRITE = 8'd10,
		OP_SNS_READ  = 8'd11,
		OP_VERSION   = 8'd16
	} cam_opcode_e;

	typedef enum logic [3:0] {
		I2C_WRITE = 4'd0,
		I2C_READ  = 4'd1
	} i2c_type_e;

	typedef enum logic {
		BUS_PB,                                   // power board
		BUS_SNS                                   // sensor board
	} i2c_bus_e;

	typedef struct packed {
		logic [7:0] data1;
		logic [7:0] data0;
	} i2c_rd_t;

	typedef struct packed {
		logic sck;
		logic n_cs;
		logic sdi;
		logic n_sync_in;
	} adc_pins_t;

endpackage
